//--- design/inv_pkg.sv
// shared widths and encodings for the inverter with an odd modulus chosen at the top level
package inv_pkg;

  // width of every operand, residue and u/v value
  localparam int DATA_WIDTH = 16;

  typedef logic [DATA_WIDTH-1:0] operand_t;

  // two steps per operand bit always drive v to zero
  localparam int ITERATIONS = 2 * DATA_WIDTH;

  // counter must reach ITERATIONS itself
  localparam int COUNT_WIDTH = $clog2(ITERATIONS + 1);

  typedef logic [COUNT_WIDTH-1:0] count_t;

  // one step of the binary extended euclid loop
  typedef enum logic [2:0] {
    STEP_HOLD,
    STEP_HALVE_U,
    STEP_HALVE_V,
    STEP_SUB_U,
    STEP_SUB_V
  } step_e;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    DECIDE,
    UPDATE,
    FINISH
  } ctrl_state_e;

endpackage

//--- design/inv_step_if.sv
// step command from the controller and u/v flags back from uv_unit, all single-cycle signals
`timescale 1ns/100ps
interface inv_step_if;

  import inv_pkg::*;

  // controller side
  logic  load;
  logic  update;
  step_e step;

  // flags straight from the u/v registers
  logic  u_even;
  logic  v_even;
  logic  u_gt_v;
  logic  v_zero;

  modport ctrl (
    output load, update, step,
    input  u_even, v_even, u_gt_v, v_zero
  );

  modport uv (
    input  load, update, step,
    output u_even, v_even, u_gt_v, v_zero
  );

  modport rs (
    input  load, update, step
  );

endinterface

//--- design/inv_control.sv
// start is a one-cycle strobe taken only in IDLE and done rises 2 + 2*ITERATIONS edges later
`timescale 1ns/100ps
module inv_control (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     start,
  output logic     busy,
  output logic     done,
  inv_step_if.ctrl step_bus
);

  import inv_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;
  count_t      iter_cnt;
  logic        last_iter;
  step_e       step_q;
  step_e       step_pick;

  assign last_iter = (iter_cnt == count_t'(ITERATIONS));

  // v zero wins, then parities, then the magnitude compare
  always_comb begin
    if (step_bus.v_zero) begin
      step_pick = STEP_HOLD;
    end else if (step_bus.u_even) begin
      step_pick = STEP_HALVE_U;
    end else if (step_bus.v_even) begin
      step_pick = STEP_HALVE_V;
    end else if (step_bus.u_gt_v) begin
      step_pick = STEP_SUB_U;
    end else begin
      step_pick = STEP_SUB_V;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_next = LOAD;
        end
      end
      LOAD: begin
        state_next = DECIDE;
      end
      DECIDE: begin
        // one extra pass through DECIDE checks the count
        if (last_iter) begin
          state_next = FINISH;
        end else begin
          state_next = UPDATE;
        end
      end
      UPDATE: begin
        state_next = DECIDE;
      end
      FINISH: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // iteration count and the step held through UPDATE
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      iter_cnt <= '0;
      step_q   <= STEP_HOLD;
    end else begin
      if (state == LOAD) begin
        iter_cnt <= '0;
      end else if (state == UPDATE) begin
        iter_cnt <= iter_cnt + 1'b1;
      end
      if (state == DECIDE) begin
        step_q <= last_iter ? STEP_HOLD : step_pick;
      end
    end
  end

  assign step_bus.load   = (state == LOAD);
  assign step_bus.update = (state == UPDATE);
  assign step_bus.step   = step_q;

  assign busy = (state != IDLE);
  assign done = (state == FINISH);

  // v has reached zero by done and the pulse lasts one cycle
  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    done |-> step_bus.v_zero ##1 (!done && !busy));

  // applied step still matches the u/v flags and the count is below its limit
  a_update_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    step_bus.update |-> !last_iter && (step_bus.step == step_pick));

endmodule

//--- design/uv_unit.sv
// v comes from the operand seen on the start cycle and MODULUS must be odd and nonzero
`timescale 1ns/100ps
module uv_unit #(
  parameter inv_pkg::operand_t MODULUS = 65521
) (
  input  logic              clk,
  input  logic              reset_n,
  input  inv_pkg::operand_t operand,
  inv_step_if.uv            step_bus
);

  import inv_pkg::*;

  operand_t operand_q;
  operand_t u;
  operand_t v;
  operand_t u_minus_v;
  operand_t v_minus_u;

  // follows the input every cycle so load sees the start-cycle operand
  always_ff @(posedge clk) begin
    operand_q <= operand;
  end

  assign u_minus_v = u - v;
  assign v_minus_u = v - u;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      u <= MODULUS;
      v <= '0;
    end else if (step_bus.load) begin
      u <= MODULUS;
      v <= operand_q;
    end else if (step_bus.update) begin
      case (step_bus.step)
        STEP_HALVE_U: begin
          u <= u >> 1;
        end
        STEP_HALVE_V: begin
          v <= v >> 1;
        end
        // both odd so the difference is even
        STEP_SUB_U: begin
          u <= u_minus_v >> 1;
        end
        STEP_SUB_V: begin
          v <= v_minus_u >> 1;
        end
        default: begin
          u <= u;
        end
      endcase
    end
  end

  // flags taken directly from the registers
  assign step_bus.u_even = ~u[0];
  assign step_bus.v_even = ~v[0];
  assign step_bus.u_gt_v = (u > v);
  assign step_bus.v_zero = (v == '0);

  // the step choice never lets u collapse to zero
  a_u_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
    step_bus.update |=> (u != '0));

endmodule

//--- design/rs_unit.sv
// r and s stay reduced below an odd MODULUS so inverse needs no final correction
`timescale 1ns/100ps
module rs_unit #(
  parameter inv_pkg::operand_t MODULUS = 65521
) (
  input  logic               clk,
  input  logic               reset_n,
  inv_step_if.rs             step_bus,
  output inv_pkg::operand_t  inverse
);

  import inv_pkg::*;

  operand_t r;
  operand_t s;

  // x/2 mod MODULUS for x below MODULUS
  function automatic operand_t mod_half(operand_t x);
    logic [DATA_WIDTH:0] sum;
    // odd x gets the modulus added so the sum is even
    sum = {1'b0, x} + (x[0] ? {1'b0, MODULUS} : '0);
    return sum[DATA_WIDTH:1];
  endfunction

  // (x - y) mod MODULUS for x and y below MODULUS
  function automatic operand_t mod_sub(operand_t x, operand_t y);
    logic [DATA_WIDTH:0] diff;
    diff = {1'b0, x} - {1'b0, y};
    if (diff[DATA_WIDTH]) begin
      diff = diff + {1'b0, MODULUS};
    end
    return diff[DATA_WIDTH-1:0];
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      r <= '0;
      s <= '0;
    end else if (step_bus.load) begin
      r <= '0;
      s <= operand_t'(1);
    end else if (step_bus.update) begin
      // same step as the u/v pair
      case (step_bus.step)
        STEP_HALVE_U: begin
          r <= mod_half(r);
        end
        STEP_HALVE_V: begin
          s <= mod_half(s);
        end
        STEP_SUB_U: begin
          r <= mod_half(mod_sub(r, s));
        end
        STEP_SUB_V: begin
          s <= mod_half(mod_sub(s, r));
        end
        default: begin
          r <= r;
        end
      endcase
    end
  end

  // r holds a^-1 once v has reached zero
  assign inverse = r;

  // residues stay reduced after every load and step
  a_rs_reduced: assert property (@(posedge clk) disable iff (!reset_n)
    (step_bus.load || step_bus.update) |=> (r < MODULUS) && (s < MODULUS));

endmodule

//--- design/mod_inverse.sv
// operand must lie below MODULUS and MODULUS must be odd, zero in gives zero out
`timescale 1ns/100ps
module mod_inverse #(
  parameter inv_pkg::operand_t MODULUS = 65521
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              start,
  input  inv_pkg::operand_t operand,
  output logic              busy,
  output logic              done,
  output inv_pkg::operand_t inverse
);

  // step command and flags between controller and datapath
  inv_step_if step_bus ();

  inv_control i_control (
    .clk      (clk),
    .reset_n  (reset_n),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .step_bus (step_bus.ctrl)
  );

  // u/v pair and its flags
  uv_unit #(
    .MODULUS (MODULUS)
  ) i_uv (
    .clk      (clk),
    .reset_n  (reset_n),
    .operand  (operand),
    .step_bus (step_bus.uv)
  );

  // r/s pair, r is the result
  rs_unit #(
    .MODULUS (MODULUS)
  ) i_rs (
    .clk      (clk),
    .reset_n  (reset_n),
    .step_bus (step_bus.rs),
    .inverse  (inverse)
  );

endmodule

//--- testbench/tb_mod_inverse.sv
// runs the default 65521 modulus only and changes every input on the falling clock edge
`timescale 1ns/100ps
module tb_mod_inverse;

  import inv_pkg::*;

  localparam int MODULUS      = 65521;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int LATENCY      = 2 + 2 * ITERATIONS;
  localparam int NUM_FIXED    = 5;
  localparam int NUM_RANDOM   = 24;
  localparam int NUM_ENTRIES  = NUM_FIXED + NUM_RANDOM;
  localparam int RESTART_EDGE = 20;
  localparam int GAP_CYCLES   = 3;

  logic     clk;
  logic     reset_n;
  logic     start;
  operand_t operand;
  logic     busy;
  logic     done;
  operand_t inverse;

  // stimulus table, one column per queue
  operand_t op_tab[$];
  operand_t exp_tab[$];
  bit       restart_tab[$];

  int unsigned error_count;
  int unsigned check_count;
  logic [31:0] rng_state;

  mod_inverse #(
    .MODULUS (operand_t'(MODULUS))
  ) i_mod_inverse (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .operand (operand),
    .busy    (busy),
    .done    (done),
    .inverse (inverse)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // iterative extended euclid on signed coefficients
  function automatic operand_t euclid_inverse(operand_t a);
    longint old_r;
    longint r;
    longint old_s;
    longint s;
    longint q;
    longint tmp;
    if (a == '0) begin
      return '0;
    end
    old_r = a;
    r     = MODULUS;
    old_s = 1;
    s     = 0;
    while (r != 0) begin
      q     = old_r / r;
      tmp   = old_r - q * r;
      old_r = r;
      r     = tmp;
      tmp   = old_s - q * s;
      old_s = s;
      s     = tmp;
    end
    old_s = old_s % MODULUS;
    if (old_s < 0) begin
      old_s = old_s + MODULUS;
    end
    return operand_t'(old_s);
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic add_entry(operand_t op, operand_t expected, bit restart);
    op_tab.push_back(op);
    exp_tab.push_back(expected);
    restart_tab.push_back(restart);
  endtask

  task automatic build_table();
    operand_t op;
    add_entry(16'd1, 16'd1, 1'b0);
    add_entry(16'd2, 16'd32761, 1'b1);
    add_entry(16'd65520, 16'd65520, 1'b0);
    add_entry(16'd3, 16'd43681, 1'b1);
    add_entry(16'd0, 16'd0, 1'b0);
    // random operands in 1 .. MODULUS-1
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng_state = xorshift32(rng_state);
      op = operand_t'(1 + rng_state % (MODULUS - 1));
      add_entry(op, euclid_inverse(op), (i % 4) == 1);
    end
  endtask

  // entered on a falling edge, leaves on a falling edge
  task automatic run_entry(int idx);
    int       edges;
    operand_t got;
    longint   prod;
    start   = 1'b1;
    operand = op_tab[idx];
    @(negedge clk);
    start = 1'b0;
    check_value("busy", 1, busy);
    edges = 0;
    while (!done && edges <= LATENCY) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (!done) begin
        check_value("busy", 1, busy);
      end
      // a second start mid-run with another operand
      if (restart_tab[idx] && edges == RESTART_EDGE) begin
        start   = 1'b1;
        operand = operand_t'((op_tab[idx] + 7) % MODULUS);
      end else begin
        start = 1'b0;
      end
    end
    if (!done) begin
      error_count++;
      $display("done did not arrive within %0d cycles of start for operand %0d",
               LATENCY + 1, op_tab[idx]);
    end else begin
      check_value("latency", LATENCY, edges);
      got = inverse;
      check_value("inverse", exp_tab[idx], got);
      if (op_tab[idx] != '0) begin
        prod = longint'(op_tab[idx]) * longint'(got) % MODULUS;
        check_value("operand*inverse mod m", 1, prod);
      end
    end
    // one-cycle done, busy falls with it
    @(negedge clk);
    check_value("done", 0, done);
    check_value("busy", 0, busy);
    check_value("inverse held", exp_tab[idx], inverse);
    repeat (GAP_CYCLES) begin
      @(negedge clk);
      check_value("done", 0, done);
    end
  endtask

  initial begin
    reset_n     = 1'b0;
    start       = 1'b0;
    operand     = '0;
    error_count = 0;
    check_count = 0;
    rng_state   = 32'd38;
    build_table();
    repeat (RESET_CYCLES) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    // idle outputs before the first start
    check_value("busy", 0, busy);
    check_value("done", 0, done);
    check_value("inverse", 0, inverse);
    for (int i = 0; i < op_tab.size(); i++) begin
      run_entry(i);
    end
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // budget of LATENCY + 10 cycles per table entry
  initial begin
    #((NUM_ENTRIES * (LATENCY + 10) + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout: done never came, run stopped at %0t ns", $time);
    $display("Errors found");
    $finish;
  end

endmodule

//--- sim.f
design/inv_pkg.sv
design/inv_step_if.sv
design/inv_control.sv
design/uv_unit.sv
design/rs_unit.sv
design/mod_inverse.sv
testbench/tb_mod_inverse.sv
